// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = enc_bridge_tb
FILELIST = enc_bridge.f
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== enc_bridge.f ====
+incdir+verilog
verilog/enc_bridge_pkg.sv
verilog/sym_fifo.sv
verilog/block_conf_rom.sv
verilog/enc_bridge_ctrl.sv
verilog/enc_bridge_top.sv
sim/enc_bridge_asserts.sv
sim/enc_bridge_tb.sv

// ==== sim/enc_bridge_asserts.sv ====
// Concurrent checks on the bridge bus and stream ports
// Bound into the top level by the testbench

`timescale 1ns/10ps

module enc_bridge_asserts
(
    input logic                    clk,
    input logic                    rst,
    input enc_bridge_pkg::wb_req_t i_req,
    input enc_bridge_pkg::wb_rsp_t i_rsp,
    input enc_bridge_pkg::enc_in_t i_enc_in
);

    // Ack is a one-cycle pulse
    ack_single: assert property (@(posedge clk) disable iff (rst)
        i_rsp.ack |=> !i_rsp.ack)
    else $error("bus acknowledge high on two consecutive cycles");

    ack_after_req: assert property (@(posedge clk) disable iff (rst)
        i_rsp.ack |-> $past(i_req.cyc && i_req.stb))
    else $error("bus acknowledge without a preceding request");

    // Checked from the second reset cycle on
    no_stream_in_reset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> !i_enc_in.valid)
    else $error("encoder input valid while reset is high");

endmodule

// ==== sim/enc_bridge_tb.sv ====
// Testbench for the encoder bridge
// Clock, reset, LFSR, bus tasks, encoder model, reference functions,
// compare tasks and the test sequence

`timescale 1ns/10ps
`include "enc_bridge_defs.svh"

module enc_bridge_tb;

    localparam int ACK_TIMEOUT   = 16;
    localparam int DRAIN_TIMEOUT = 64;
    localparam int FRAME_TIMEOUT = 32;
    localparam int NUM_FRAMES    = 5;
    localparam enc_bridge_pkg::wb_word_t ALIVE_MASK = 32'h1 << `ENC_STAT_ALIVE_BIT;
    localparam enc_bridge_pkg::wb_word_t FRAME_MASK = 32'h1 << `ENC_STAT_FRAME_BIT;
    localparam enc_bridge_pkg::wb_word_t STAT_MASK  = 32'hffff_ff00;

    logic                        clk = 1'b0;
    logic                        rst;
    enc_bridge_pkg::wb_req_t     req;
    enc_bridge_pkg::wb_rsp_t     rsp;
    enc_bridge_pkg::param_sel_t  param_sel;
    enc_bridge_pkg::enc_in_t     enc_in;
    enc_bridge_pkg::enc_out_t    enc_out;
    enc_bridge_pkg::block_conf_t conf;

    logic [31:0]               lfsr_state;
    logic                      eof_pushed;
    enc_bridge_pkg::rx_entry_t sent_q [$];
    enc_bridge_pkg::rx_entry_t seen_q [$];

    enc_bridge_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .i_req       (req),
        .o_rsp       (rsp),
        .i_param_sel (param_sel),
        .o_enc_in    (enc_in),
        .i_enc_out   (enc_out),
        .o_conf      (conf)
    );

    bind enc_bridge_top enc_bridge_asserts u_asserts (
        .clk      (clk),
        .rst      (rst),
        .i_req    (i_req),
        .i_rsp    (o_rsp),
        .i_enc_in (o_enc_in)
    );

    always #50 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // Frame position modulo 16 sits above the input symbol
    function automatic enc_bridge_pkg::tx_entry_t expect_tx(input enc_bridge_pkg::rx_entry_t e,
                                                            input int pos);
        enc_bridge_pkg::tx_entry_t t;
        t.eof = e.eof;
        t.bof = e.bof;
        t.sym = enc_bridge_pkg::out_sym_t'(((pos % 16) * 4) + int'(e.sym));
        return t;
    endfunction

    function automatic enc_bridge_pkg::block_conf_t expect_conf(
        input enc_bridge_pkg::param_sel_t sel);
        enc_bridge_pkg::block_conf_t c;
        c = '0;
        case (sel)
            6'd0:  c = '{blocksize: 10'd14, p: 10'd9, q0: 12'd3, q1: 12'd11,
                         q2: 12'd51, q3: 12'd19};
            6'd17: c = '{blocksize: 10'd144, p: 10'd31, q0: 12'd3, q1: 12'd3,
                         q2: 12'd3, q3: 12'd3};
            6'd31: c = '{blocksize: 10'd444, p: 10'd59, q0: 12'd3, q1: 12'd35,
                         q2: 12'd731, q3: 12'd715};
            // Repeats entry 4
            6'd33: c = '{blocksize: 10'd59, p: 10'd23, q0: 12'd3, q1: 12'd11,
                         q2: 12'd23, q3: 12'd219};
            default: c = '0;
        endcase
        return c;
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input enc_bridge_pkg::wb_word_t exp,
                              input enc_bridge_pkg::wb_word_t act);
        if (act !== exp)
            stop_on_error($sformatf("FAILED %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_tx(input string name, input enc_bridge_pkg::tx_entry_t exp,
                            input enc_bridge_pkg::tx_entry_t act);
        if (act !== exp)
            stop_on_error($sformatf("FAILED %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_rx(input string name, input enc_bridge_pkg::rx_entry_t exp,
                            input enc_bridge_pkg::rx_entry_t act);
        if (act !== exp)
            stop_on_error($sformatf("FAILED %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_conf(input string name, input enc_bridge_pkg::block_conf_t exp,
                              input enc_bridge_pkg::block_conf_t act);
        if (act !== exp)
            stop_on_error($sformatf("FAILED %s expected %h actual %h", name, exp, act));
    endtask

    // Starts and ends 5 ns after a rising edge; stb drops in the ack cycle
    task automatic bus_access(input logic we, input enc_bridge_pkg::wb_word_t wdata,
                              output enc_bridge_pkg::wb_word_t rdata);
        int   waited;
        logic got_ack;
        waited  = 0;
        got_ack = 1'b0;
        rdata   = '0;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.dat = wdata;
        while (!got_ack)
        begin
            @(posedge clk);
            #1;
            if (rsp.ack)
            begin
                got_ack = 1'b1;
                rdata   = rsp.dat;
            end
            else
            begin
                waited++;
                if (waited > ACK_TIMEOUT)
                    stop_on_error("no bus acknowledge within the timeout");
            end
            #4;
        end
        req = '0;
        @(posedge clk);
        #1;
        if (rsp.ack)
            stop_on_error("bus acknowledge lasted more than one cycle");
        #4;
        check_word("alive bit", ALIVE_MASK, rdata & ALIVE_MASK);
    endtask

    task automatic push_sym(input enc_bridge_pkg::rx_entry_t e);
        enc_bridge_pkg::wb_word_t w;
        enc_bridge_pkg::wb_word_t rd;
        w = '0;
        w[`ENC_CMD_PUSH_BIT] = 1'b1;
        w[`ENC_CMD_EOF_BIT]  = e.eof;
        w[`ENC_CMD_BOF_BIT]  = e.bof;
        w[1:0]               = e.sym;
        bus_access(1'b1, w, rd);
    endtask

    task automatic read_status(input logic rden, output enc_bridge_pkg::wb_word_t rd);
        enc_bridge_pkg::wb_word_t w;
        w = '0;
        w[`ENC_CMD_RDEN_BIT] = rden;
        bus_access(1'b0, w, rd);
    endtask

    task automatic run_frame(input int frame_no);
        logic [31:0]               v;
        int                        len;
        int                        base;
        int                        waited;
        enc_bridge_pkg::rx_entry_t e;
        enc_bridge_pkg::wb_word_t  rd;
        draw_bits(4, v);
        len  = int'(v % 32'd12) + 1;
        base = seen_q.size();
        sent_q.delete();
        eof_pushed = 1'b0;
        for (int i = 0; i < len; i++)
        begin
            draw_bits(2, v);
            e.sym = v[1:0];
            e.bof = (i == 0);
            e.eof = (i == len - 1);
            sent_q.push_back(e);
            if (e.eof)
                eof_pushed = 1'b1;
            push_sym(e);
        end

        waited = 0;
        while (seen_q.size() < base + len)
        begin
            @(posedge clk);
            #5;
            waited++;
            if (waited > DRAIN_TIMEOUT)
                stop_on_error("receive FIFO did not drain to the encoder");
        end
        for (int i = 0; i < len; i++)
            check_rx($sformatf("frame %0d drain %0d", frame_no, i), sent_q[i], seen_q[base + i]);

        waited = 0;
        read_status(1'b0, rd);
        while (!rd[`ENC_STAT_FRAME_BIT])
        begin
            waited++;
            if (waited > FRAME_TIMEOUT)
                stop_on_error("frame bit never set after the encoder returned a frame");
            read_status(1'b0, rd);
        end
        // A read without RDEN leaves the head in place
        check_tx("head peek", expect_tx(sent_q[0], 0), rd[7:0]);
        read_status(1'b0, rd);
        check_tx("head peek again", expect_tx(sent_q[0], 0), rd[7:0]);

        for (int i = 0; i < len; i++)
        begin
            read_status(1'b1, rd);
            check_word("status while frame waits", FRAME_MASK | ALIVE_MASK, rd & STAT_MASK);
            check_tx($sformatf("frame %0d readback %0d", frame_no, i),
                     expect_tx(sent_q[i], i), rd[7:0]);
        end
        read_status(1'b0, rd);
        check_word("status after last pop", ALIVE_MASK, rd & STAT_MASK);
        if (seen_q.size() != base + len)
            stop_on_error("encoder received more symbols than were pushed");
    endtask

    // Encoder model collects a frame, then returns it one entry per cycle
    initial
    begin : encoder_model
        enc_bridge_pkg::rx_entry_t frame_q [$];
        enc_out = '0;
        forever
        begin
            @(negedge clk);
            if (!rst && enc_in.valid)
            begin
                if (!eof_pushed)
                    stop_on_error("symbol sent to the encoder before the frame end was pushed");
                seen_q.push_back(enc_in.entry);
                frame_q.push_back(enc_in.entry);
                if (enc_in.entry.eof)
                begin
                    for (int i = 0; i < frame_q.size(); i++)
                    begin
                        @(posedge clk);
                        #5;
                        enc_out.valid     = 1'b1;
                        enc_out.entry.eof = frame_q[i].eof;
                        enc_out.entry.bof = frame_q[i].bof;
                        enc_out.entry.sym = {i[3:0], frame_q[i].sym};
                    end
                    @(posedge clk);
                    #5;
                    enc_out = '0;
                    frame_q.delete();
                end
            end
        end
    end

    initial
    begin : test_sequence
        enc_bridge_pkg::param_sel_t sels [5];
        sels       = '{6'd0, 6'd17, 6'd31, 6'd33, 6'd50};
        lfsr_state = 32'h140b_a1fb;
        rst        = 1'b1;
        req        = '0;
        param_sel  = '0;
        eof_pushed = 1'b0;
        repeat (8) @(posedge clk);
        #5;
        rst = 1'b0;

        @(negedge clk);
        if (rsp.ack !== 1'b0)
            stop_on_error("bus acknowledge high after reset");
        if (enc_in.valid !== 1'b0)
            stop_on_error("encoder input valid high after reset");
        @(posedge clk);
        #5;

        for (int f = 0; f < NUM_FRAMES; f++)
            run_frame(f);

        // Table output two cycles after each select change
        foreach (sels[i])
        begin
            param_sel = sels[i];
            repeat (2) @(posedge clk);
            #1;
            check_conf($sformatf("conf select %0d", sels[i]), expect_conf(sels[i]), conf);
            #4;
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== verilog/block_conf_rom.sv ====
// Encoder block configuration table
// Registered lookup of block size, P and Q values by parameter select

`timescale 1ns/10ps
`include "enc_bridge_defs.svh"

module block_conf_rom
(
    input  logic                        clk,
    input  logic                        rst,
    input  enc_bridge_pkg::param_sel_t  i_sel,
    output enc_bridge_pkg::block_conf_t o_conf
);
    enc_bridge_pkg::block_conf_t conf_d;

    function automatic enc_bridge_pkg::block_conf_t mk_conf(input int bs, input int p,
                                                            input int q0, input int q1,
                                                            input int q2, input int q3);
        enc_bridge_pkg::block_conf_t c;
        c.blocksize = enc_bridge_pkg::blocksize_t'(bs);
        c.p         = enc_bridge_pkg::conf_p_t'(p);
        c.q0        = enc_bridge_pkg::conf_q_t'(q0);
        c.q1        = enc_bridge_pkg::conf_q_t'(q1);
        c.q2        = enc_bridge_pkg::conf_q_t'(q2);
        c.q3        = enc_bridge_pkg::conf_q_t'(q3);
        return c;
    endfunction

    always_comb
    begin
        conf_d = '0;
        if (i_sel < `ENC_CONF_COUNT)
        begin
            case (i_sel)
                6'd0:  conf_d = mk_conf(14, 9, 3, 11, 51, 19);
                6'd1:  conf_d = mk_conf(38, 17, 3, 23, 63, 11);
                6'd2:  conf_d = mk_conf(51, 23, 3, 23, 107, 107);
                6'd3:  conf_d = mk_conf(55, 23, 3, 43, 131, 115);
                6'd4:  conf_d = mk_conf(59, 23, 3, 11, 23, 219);
                6'd5:  conf_d = mk_conf(62, 23, 3, 35, 63, 63);
                6'd6:  conf_d = mk_conf(69, 25, 3, 7, 111, 103);
                6'd7:  conf_d = mk_conf(84, 23, 3, 7, 83, 71);
                6'd8:  conf_d = mk_conf(85, 23, 3, 55, 255, 215);
                6'd9:  conf_d = mk_conf(93, 25, 3, 31, 111, 107);
                6'd10: conf_d = mk_conf(96, 25, 3, 11, 103, 107);
                6'd11: conf_d = mk_conf(100, 23, 3, 35, 131, 127);
                6'd12: conf_d = mk_conf(108, 29, 3, 19, 123, 123);
                6'd13: conf_d = mk_conf(115, 29, 3, 23, 239, 239);
                6'd14: conf_d = mk_conf(123, 31, 3, 15, 7, 3);
                6'd15: conf_d = mk_conf(128, 31, 3, 7, 135, 131);
                6'd16: conf_d = mk_conf(130, 31, 3, 7, 11, 3);
                6'd17: conf_d = mk_conf(144, 31, 3, 3, 3, 3);
                6'd18: conf_d = mk_conf(170, 33, 3, 63, 523, 515);
                6'd19: conf_d = mk_conf(175, 37, 3, 11, 3, 11);
                6'd20: conf_d = mk_conf(188, 37, 3, 15, 167, 159);
                6'd21: conf_d = mk_conf(192, 37, 3, 7, 183, 123);
                6'd22: conf_d = mk_conf(194, 39, 3, 3, 319, 319);
                6'd23: conf_d = mk_conf(256, 45, 3, 7, 199, 183);
                6'd24: conf_d = mk_conf(264, 43, 3, 3, 27, 11);
                6'd25: conf_d = mk_conf(298, 49, 3, 15, 23, 3);
                6'd26: conf_d = mk_conf(307, 49, 3, 27, 3, 7);
                6'd27: conf_d = mk_conf(333, 49, 3, 23, 3, 23);
                6'd28: conf_d = mk_conf(355, 53, 3, 19, 239, 223);
                6'd29: conf_d = mk_conf(400, 53, 3, 43, 243, 219);
                6'd30: conf_d = mk_conf(438, 59, 3, 7, 247, 243);
                6'd31: conf_d = mk_conf(444, 59, 3, 35, 731, 715);
                6'd32: conf_d = mk_conf(539, 65, 3, 15, 31, 3);
                // Same block as entry 4
                6'd33: conf_d = mk_conf(59, 23, 3, 11, 23, 219);
                default: conf_d = '0;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            o_conf <= '0;
        else
            o_conf <= conf_d;
    end

endmodule

// ==== verilog/enc_bridge_ctrl.sv ====
// Bridge controller
// Bus acknowledge, command decode, receive drain and frame-ready flags

`timescale 1ns/10ps
`include "enc_bridge_defs.svh"

module enc_bridge_ctrl
(
    input  logic                    clk,
    input  logic                    rst,
    input  enc_bridge_pkg::wb_req_t i_req,
    input  logic                    i_rx_empty,
    input  logic                    i_tx_empty,
    input  logic                    i_tx_eof_in,
    output logic                    o_ack,
    output logic                    o_rx_push,
    output logic                    o_rx_pop,
    output logic                    o_tx_pop,
    output logic                    o_frame_ready
);
    enc_bridge_pkg::bus_phase_t phase;
    logic access;
    logic drain_start;
    logic drain_active;
    logic frame_ready;
    logic rden;

    // New access only taken in the idle phase
    assign access      = i_req.cyc && i_req.stb && (phase == enc_bridge_pkg::PHASE_IDLE);
    assign o_rx_push   = access && i_req.we && i_req.dat[`ENC_CMD_PUSH_BIT];
    assign drain_start = o_rx_push && i_req.dat[`ENC_CMD_EOF_BIT];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            phase <= enc_bridge_pkg::PHASE_IDLE;
        end
        else
        begin
            case (phase)
                enc_bridge_pkg::PHASE_IDLE:
                begin
                    if (access)
                    begin
                        phase <= enc_bridge_pkg::PHASE_ACK;
                    end
                end
                default:
                begin
                    phase <= enc_bridge_pkg::PHASE_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            drain_active <= 1'b0;
            frame_ready  <= 1'b0;
            rden         <= 1'b0;
        end
        else
        begin
            // Set wins, so a one-symbol frame into an empty FIFO still drains
            if (drain_start)
                drain_active <= 1'b1;
            else if (i_rx_empty)
                drain_active <= 1'b0;

            if (i_tx_eof_in)
                frame_ready <= 1'b1;
            else if (i_tx_empty)
                frame_ready <= 1'b0;

            if (access)
                rden <= i_req.dat[`ENC_CMD_RDEN_BIT];
        end
    end

    assign o_ack         = (phase == enc_bridge_pkg::PHASE_ACK);
    assign o_rx_pop      = drain_active && !i_rx_empty;
    // Read word is sampled from the head before this pop takes effect
    assign o_tx_pop      = o_ack && rden;
    assign o_frame_ready = frame_ready;

endmodule

// ==== verilog/enc_bridge_defs.svh ====
// Shared constants for the bus-to-stream encoder bridge
// FIFO depth, command word bit positions, status bits, table size

`ifndef ENC_BRIDGE_DEFS_SVH
`define ENC_BRIDGE_DEFS_SVH

// 256 entries per FIFO
`define ENC_FIFO_ADDR_W     8

// Command word bits on a bus write
`define ENC_CMD_PUSH_BIT    15
`define ENC_CMD_RDEN_BIT    13
`define ENC_CMD_EOF_BIT     7
`define ENC_CMD_BOF_BIT     6

// Status bits in the read word
`define ENC_STAT_FRAME_BIT  15
`define ENC_STAT_ALIVE_BIT  14

`define ENC_CONF_COUNT      34

`endif

// ==== verilog/enc_bridge_pkg.sv ====
// Types for the encoder bridge
// Vector typedefs, bus and stream structs, bus phase enum

package enc_bridge_pkg;

    typedef logic [31:0] wb_word_t;
    typedef logic [1:0]  in_sym_t;
    typedef logic [5:0]  out_sym_t;
    typedef logic [5:0]  param_sel_t;
    typedef logic [9:0]  blocksize_t;
    typedef logic [9:0]  conf_p_t;
    typedef logic [11:0] conf_q_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_word_t dat;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_word_t dat;
    } wb_rsp_t;

    // Flags sit above the symbol, as stored in the FIFOs
    typedef struct packed {
        logic    eof;
        logic    bof;
        in_sym_t sym;
    } rx_entry_t;

    typedef struct packed {
        logic     eof;
        logic     bof;
        out_sym_t sym;
    } tx_entry_t;

    typedef struct packed {
        logic      valid;
        rx_entry_t entry;
    } enc_in_t;

    typedef struct packed {
        logic      valid;
        tx_entry_t entry;
    } enc_out_t;

    typedef struct packed {
        blocksize_t blocksize;
        conf_p_t    p;
        conf_q_t    q0;
        conf_q_t    q1;
        conf_q_t    q2;
        conf_q_t    q3;
    } block_conf_t;

    typedef enum logic {
        PHASE_IDLE,
        PHASE_ACK
    } bus_phase_t;

endpackage

// ==== verilog/enc_bridge_top.sv ====
// Encoder bridge top level
// Controller, receive and transmit symbol FIFOs, block configuration ROM
// Stream and configuration ports go to the external encoder core

`timescale 1ns/10ps
`include "enc_bridge_defs.svh"

module enc_bridge_top
(
    input  logic                        clk,
    input  logic                        rst,
    input  enc_bridge_pkg::wb_req_t     i_req,
    output enc_bridge_pkg::wb_rsp_t     o_rsp,
    input  enc_bridge_pkg::param_sel_t  i_param_sel,
    output enc_bridge_pkg::enc_in_t     o_enc_in,
    input  enc_bridge_pkg::enc_out_t    i_enc_out,
    output enc_bridge_pkg::block_conf_t o_conf
);
    logic                      rx_push;
    logic                      rx_pop;
    logic                      rx_empty;
    logic                      tx_pop;
    logic                      tx_empty;
    logic                      tx_eof_in;
    logic                      ack;
    logic                      frame_ready;
    enc_bridge_pkg::rx_entry_t rx_wdata;
    enc_bridge_pkg::rx_entry_t rx_head;
    enc_bridge_pkg::tx_entry_t tx_head;

    // Symbol and flags from the command word
    assign rx_wdata.eof = i_req.dat[`ENC_CMD_EOF_BIT];
    assign rx_wdata.bof = i_req.dat[`ENC_CMD_BOF_BIT];
    assign rx_wdata.sym = i_req.dat[1:0];

    assign tx_eof_in = i_enc_out.valid && i_enc_out.entry.eof;

    enc_bridge_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .i_req         (i_req),
        .i_rx_empty    (rx_empty),
        .i_tx_empty    (tx_empty),
        .i_tx_eof_in   (tx_eof_in),
        .o_ack         (ack),
        .o_rx_push     (rx_push),
        .o_rx_pop      (rx_pop),
        .o_tx_pop      (tx_pop),
        .o_frame_ready (frame_ready)
    );

    sym_fifo #(.DATA_W(4), .ADDR_W(`ENC_FIFO_ADDR_W)) u_rx_fifo (
        .clk     (clk),
        .rst     (rst),
        .i_wr    (rx_push),
        .i_wdata (rx_wdata),
        .i_rd    (rx_pop),
        .o_rdata (rx_head),
        .o_empty (rx_empty),
        .o_full  ()
    );

    sym_fifo #(.DATA_W(8), .ADDR_W(`ENC_FIFO_ADDR_W)) u_tx_fifo (
        .clk     (clk),
        .rst     (rst),
        .i_wr    (i_enc_out.valid),
        .i_wdata (i_enc_out.entry),
        .i_rd    (tx_pop),
        .o_rdata (tx_head),
        .o_empty (tx_empty),
        .o_full  ()
    );

    block_conf_rom u_conf_rom (
        .clk    (clk),
        .rst    (rst),
        .i_sel  (i_param_sel),
        .o_conf (o_conf)
    );

    // Symbol lines stay quiet between pops
    assign o_enc_in.valid = rx_pop;
    assign o_enc_in.entry = rx_pop ? rx_head : '0;

    assign o_rsp.ack = ack;
    assign o_rsp.dat = (enc_bridge_pkg::wb_word_t'(frame_ready) << `ENC_STAT_FRAME_BIT) |
                       (enc_bridge_pkg::wb_word_t'(1'b1) << `ENC_STAT_ALIVE_BIT) |
                       enc_bridge_pkg::wb_word_t'(tx_head);

endmodule

// ==== verilog/sym_fifo.sv ====
// Synchronous symbol FIFO
// Circular buffer with a combinational head word and full/empty flags

`timescale 1ns/10ps

module sym_fifo
#(
    parameter int DATA_W = 8,
    parameter int ADDR_W = 8
)
(
    input  logic              clk,
    input  logic              rst,
    input  logic              i_wr,
    input  logic [DATA_W-1:0] i_wdata,
    input  logic              i_rd,
    output logic [DATA_W-1:0] o_rdata,
    output logic              o_empty,
    output logic              o_full
);
    logic [DATA_W-1:0] mem [0:(1 << ADDR_W)-1];
    // Extra pointer bit tells full from empty
    logic [ADDR_W:0]   wr_ptr;
    logic [ADDR_W:0]   rd_ptr;
    logic              rd_en;
    logic              wr_en;

    assign o_empty = (wr_ptr == rd_ptr);
    assign o_full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                     (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign rd_en = i_rd && !o_empty;
    // A read in the same cycle frees a slot for the write
    assign wr_en = i_wr && (!o_full || rd_en);

    assign o_rdata = mem[rd_ptr[ADDR_W-1:0]];

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_ptr[ADDR_W-1:0]] <= i_wdata;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule
